// ==== verilog/fpu_pkg.sv ====
package fpu_pkg;

    // ========================================================
    // Operation codes
    // ========================================================

    // Code 3 is unused and lands on the multiplier
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } op_e;

    // ========================================================
    // Exception flags
    // ========================================================

    localparam int FLAG_W = 4;

    localparam int FLAG_INEXACT   = 3;
    localparam int FLAG_INVALID   = 2;
    localparam int FLAG_OVERFLOW  = 1;
    localparam int FLAG_UNDERFLOW = 0;

    // ========================================================
    // Operand class
    // ========================================================

    // Also used as the special code of an arithmetic outcome
    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0,
        CLS_NORMAL = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } cls_t;

endpackage

// ==== verilog/fp_unpack.sv ====
module fp_unpack
    import fpu_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  logic [EXP_W+MAN_W:0] word,
    output logic                 sign,
    output logic [EXP_W-1:0]     exp,
    output logic [MAN_W:0]       sig,
    output cls_t                 cls
);

    localparam int W = 1 + EXP_W + MAN_W;

    logic [MAN_W-1:0] frac;

    assign sign = word[W-1];
    assign exp  = word[W-2 -: EXP_W];
    assign frac = word[MAN_W-1:0];

    // Zero exponent also covers subnormals, read as zero
    always_comb begin
        if (exp == '1) begin
            cls = (frac == '0) ? CLS_INF : CLS_NAN;
        end else if (exp == '0) begin
            cls = CLS_ZERO;
        end else begin
            cls = CLS_NORMAL;
        end
    end

    // Hidden one only for normal operands
    assign sig = {cls == CLS_NORMAL, frac};

endmodule

// ==== verilog/fp_addsub.sv ====
module fp_addsub
    import fpu_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  logic                    sign_a,
    input  logic [EXP_W-1:0]        exp_a,
    input  logic [MAN_W:0]          sig_a,
    input  cls_t                    cls_a,
    input  logic                    sign_b,
    input  logic [EXP_W-1:0]        exp_b,
    input  logic [MAN_W:0]          sig_b,
    input  cls_t                    cls_b,
    input  logic                    sub,
    output logic                    o_sign,
    output logic signed [EXP_W+1:0] o_exp,
    output logic [MAN_W+3:0]        o_sig,
    output cls_t                    o_special,
    output logic                    o_special_sign
);

    // Significand plus guard, round and sticky
    localparam int GW   = MAN_W + 4;
    localparam int LZ_W = $clog2(GW);

    logic             sign_b_eff;
    logic             swap;
    logic             sign_l;
    logic [EXP_W-1:0] exp_l;
    logic [EXP_W-1:0] exp_s;
    logic [EXP_W-1:0] exp_diff;
    logic [GW-1:0]    ext_l;
    logic [GW-1:0]    ext_s;
    logic [GW-1:0]    shifted;
    logic [GW-1:0]    lost;
    logic [GW-1:0]    ext_s_al;
    logic [GW:0]      sum;
    logic [LZ_W-1:0]  lz;
    logic [GW-1:0]    sum_norm;

    assign sign_b_eff = sign_b ^ sub;

    // Larger magnitude goes first
    assign swap   = {exp_b, sig_b} > {exp_a, sig_a};
    assign sign_l = swap ? sign_b_eff : sign_a;
    assign exp_l  = swap ? exp_b : exp_a;
    assign exp_s  = swap ? exp_a : exp_b;
    assign ext_l  = swap ? {sig_b, 3'b000} : {sig_a, 3'b000};
    assign ext_s  = swap ? {sig_a, 3'b000} : {sig_b, 3'b000};

    // ========================================================
    // Alignment with sticky collection
    // ========================================================

    assign exp_diff = exp_l - exp_s;
    assign shifted  = ext_s >> exp_diff;
    assign lost     = ext_s & ~({GW{1'b1}} << exp_diff);
    assign ext_s_al = {shifted[GW-1:1], shifted[0] | (|lost)};

    assign sum = (sign_a ^ sign_b_eff) ? {1'b0, ext_l} - {1'b0, ext_s_al}
                                       : {1'b0, ext_l} + {1'b0, ext_s_al};

    // Highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < GW; i++) begin
            if (sum[i]) begin
                lz = LZ_W'(GW - 1 - i);
            end
        end
    end

    assign sum_norm = sum[GW-1:0] << lz;

    // ========================================================
    // Normalization and special cases
    // ========================================================

    always_comb begin
        o_sign         = sign_l;
        o_exp          = {2'b00, exp_l} - (EXP_W + 2)'(lz);
        o_sig          = sum_norm;
        o_special      = CLS_NORMAL;
        o_special_sign = 1'b0;
        if (sum[GW]) begin
            // Carry out, one step right
            o_exp = {2'b00, exp_l} + 1'b1;
            o_sig = {sum[GW:2], sum[1] | sum[0]};
        end else if (sum == '0) begin
            o_special = CLS_ZERO;
        end

        if (cls_a == CLS_NAN || cls_b == CLS_NAN ||
            (cls_a == CLS_INF && cls_b == CLS_INF && sign_a != sign_b_eff)) begin
            o_special = CLS_NAN;
        end else if (cls_a == CLS_INF) begin
            o_special      = CLS_INF;
            o_special_sign = sign_a;
        end else if (cls_b == CLS_INF) begin
            o_special      = CLS_INF;
            o_special_sign = sign_b_eff;
        end else if (cls_a == CLS_ZERO && cls_b == CLS_ZERO) begin
            o_special      = CLS_ZERO;
            o_special_sign = sign_a & sign_b_eff;
        end else if (cls_a == CLS_ZERO) begin
            o_special = CLS_NORMAL;
            o_sign    = sign_b_eff;
            o_exp     = {2'b00, exp_b};
            o_sig     = {sig_b, 3'b000};
        end else if (cls_b == CLS_ZERO) begin
            o_special = CLS_NORMAL;
            o_sign    = sign_a;
            o_exp     = {2'b00, exp_a};
            o_sig     = {sig_a, 3'b000};
        end
    end

endmodule

// ==== verilog/fp_mul.sv ====
module fp_mul
    import fpu_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  logic                    sign_a,
    input  logic [EXP_W-1:0]        exp_a,
    input  logic [MAN_W:0]          sig_a,
    input  cls_t                    cls_a,
    input  logic                    sign_b,
    input  logic [EXP_W-1:0]        exp_b,
    input  logic [MAN_W:0]          sig_b,
    input  cls_t                    cls_b,
    output logic                    o_sign,
    output logic signed [EXP_W+1:0] o_exp,
    output logic [MAN_W+3:0]        o_sig,
    output cls_t                    o_special,
    output logic                    o_special_sign
);

    localparam int BIAS = (1 << (EXP_W - 1)) - 1;

    logic [2*MAN_W+1:0] prod;
    logic [2*MAN_W+1:0] norm;
    logic [EXP_W+1:0]   exp_sum;

    assign prod    = sig_a * sig_b;
    assign exp_sum = {2'b00, exp_a} + {2'b00, exp_b} - (EXP_W + 2)'(BIAS);

    // Product lies in [1, 4), bring the leading one to the top
    assign norm = prod[2*MAN_W+1] ? prod : prod << 1;

    assign o_sign = sign_a ^ sign_b;
    assign o_exp  = exp_sum + prod[2*MAN_W+1];
    // Hidden, fraction, guard, round, then sticky from the rest
    assign o_sig  = {norm[2*MAN_W+1 -: MAN_W+3], |norm[MAN_W-2:0]};

    assign o_special_sign = sign_a ^ sign_b;

    always_comb begin
        if (cls_a == CLS_NAN || cls_b == CLS_NAN ||
            (cls_a == CLS_ZERO && cls_b == CLS_INF) ||
            (cls_a == CLS_INF && cls_b == CLS_ZERO)) begin
            o_special = CLS_NAN;
        end else if (cls_a == CLS_INF || cls_b == CLS_INF) begin
            o_special = CLS_INF;
        end else if (cls_a == CLS_ZERO || cls_b == CLS_ZERO) begin
            o_special = CLS_ZERO;
        end else begin
            o_special = CLS_NORMAL;
        end
    end

endmodule

// ==== verilog/fp_pack.sv ====
module fp_pack
    import fpu_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  logic                    add_sign,
    input  logic signed [EXP_W+1:0] add_exp,
    input  logic [MAN_W+3:0]        add_sig,
    input  cls_t                    add_special,
    input  logic                    add_special_sign,
    input  logic                    mul_sign,
    input  logic signed [EXP_W+1:0] mul_exp,
    input  logic [MAN_W+3:0]        mul_sig,
    input  cls_t                    mul_special,
    input  logic                    mul_special_sign,
    input  logic                    sel_mul,
    output logic [EXP_W+MAN_W:0]    res_next,
    output logic [FLAG_W-1:0]       flags_next
);

    // All-ones biased exponent
    localparam logic signed [EXP_W+1:0] EXP_MAX = (EXP_W + 2)'((1 << EXP_W) - 1);

    logic                    sign;
    logic signed [EXP_W+1:0] exp_v;
    logic [MAN_W+3:0]        sig;
    cls_t                    special;
    logic                    special_sign;
    logic                    grs_nz;

    assign sign         = sel_mul ? mul_sign : add_sign;
    assign exp_v        = sel_mul ? mul_exp : add_exp;
    assign sig          = sel_mul ? mul_sig : add_sig;
    assign special      = sel_mul ? mul_special : add_special;
    assign special_sign = sel_mul ? mul_special_sign : add_special_sign;

    // Bits dropped by truncation
    assign grs_nz = |sig[2:0];

    always_comb begin
        res_next   = '0;
        flags_next = '0;
        case (special)
            CLS_NAN: begin
                res_next = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MAN_W - 1){1'b0}}};
                flags_next[FLAG_INVALID] = 1'b1;
            end
            CLS_INF: begin
                res_next = {special_sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
            end
            CLS_ZERO: begin
                res_next = {special_sign, {(EXP_W + MAN_W){1'b0}}};
            end
            default: begin
                if (exp_v >= EXP_MAX) begin
                    res_next = {sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
                    flags_next[FLAG_OVERFLOW] = 1'b1;
                    flags_next[FLAG_INEXACT]  = 1'b1;
                end else if (exp_v <= 0) begin
                    // Below smallest normal, flush
                    res_next = {sign, {(EXP_W + MAN_W){1'b0}}};
                    flags_next[FLAG_UNDERFLOW] = 1'b1;
                    flags_next[FLAG_INEXACT]   = 1'b1;
                end else begin
                    res_next = {sign, exp_v[EXP_W-1:0], sig[MAN_W+2:3]};
                    flags_next[FLAG_INEXACT] = grs_nz;
                end
            end
        endcase
    end

endmodule

// ==== verilog/fpu_ctrl.sv ====
module fpu_ctrl
    import fpu_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  op_e                  op,
    input  logic [EXP_W+MAN_W:0] op_a,
    input  logic [EXP_W+MAN_W:0] op_b,
    output logic [EXP_W+MAN_W:0] a_q,
    output logic [EXP_W+MAN_W:0] b_q,
    output op_e                  op_q,
    input  logic [EXP_W+MAN_W:0] res_next,
    input  logic [FLAG_W-1:0]    flags_next,
    output logic [EXP_W+MAN_W:0] result,
    output logic [FLAG_W-1:0]    flags,
    output logic                 valid_out
);

    typedef enum logic {
        IDLE    = 1'b0,
        COMPUTE = 1'b1
    } state_t;

    state_t state;
    logic   accept;

    // Start only counts while idle
    assign accept = (state == IDLE) && start;

    // ========================================================
    // Sequencer
    // ========================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= start ? COMPUTE : IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Operands stay stable for the datapath during compute
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q  <= op_a;
            b_q  <= op_b;
            op_q <= op;
        end
    end

    // ========================================================
    // Output registers
    // ========================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result    <= '0;
            flags     <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= (state == COMPUTE);
            if (state == COMPUTE) begin
                result <= res_next;
                flags  <= flags_next;
            end
        end
    end

endmodule

// ==== verilog/fpu_top.sv ====
module fpu_top
    import fpu_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  op_e                  op,
    input  logic [EXP_W+MAN_W:0] op_a,
    input  logic [EXP_W+MAN_W:0] op_b,
    output logic [EXP_W+MAN_W:0] result,
    output logic [FLAG_W-1:0]    flags,
    output logic                 valid_out
);

    logic [EXP_W+MAN_W:0] a_q;
    logic [EXP_W+MAN_W:0] b_q;
    op_e                  op_q;

    // Unpacked operands
    logic             sign_a;
    logic [EXP_W-1:0] exp_a;
    logic [MAN_W:0]   sig_a;
    cls_t             cls_a;
    logic             sign_b;
    logic [EXP_W-1:0] exp_b;
    logic [MAN_W:0]   sig_b;
    cls_t             cls_b;

    // Outcome bundles
    logic                    add_sign;
    logic signed [EXP_W+1:0] add_exp;
    logic [MAN_W+3:0]        add_sig;
    cls_t                    add_special;
    logic                    add_special_sign;
    logic                    mul_sign;
    logic signed [EXP_W+1:0] mul_exp;
    logic [MAN_W+3:0]        mul_sig;
    cls_t                    mul_special;
    logic                    mul_special_sign;

    logic [EXP_W+MAN_W:0] res_next;
    logic [FLAG_W-1:0]    flags_next;

    fpu_ctrl #(.EXP_W(EXP_W), .MAN_W(MAN_W)) u_ctrl (
        .clk(clk), .rst(rst), .start(start), .op(op), .op_a(op_a), .op_b(op_b),
        .a_q(a_q), .b_q(b_q), .op_q(op_q), .res_next(res_next), .flags_next(flags_next),
        .result(result), .flags(flags), .valid_out(valid_out)
    );

    fp_unpack #(.EXP_W(EXP_W), .MAN_W(MAN_W)) u_unpack_a (
        .word(a_q), .sign(sign_a), .exp(exp_a), .sig(sig_a), .cls(cls_a)
    );

    fp_unpack #(.EXP_W(EXP_W), .MAN_W(MAN_W)) u_unpack_b (
        .word(b_q), .sign(sign_b), .exp(exp_b), .sig(sig_b), .cls(cls_b)
    );

    fp_addsub #(.EXP_W(EXP_W), .MAN_W(MAN_W)) u_addsub (
        .sign_a(sign_a), .exp_a(exp_a), .sig_a(sig_a), .cls_a(cls_a),
        .sign_b(sign_b), .exp_b(exp_b), .sig_b(sig_b), .cls_b(cls_b),
        .sub(op_q[0]),
        .o_sign(add_sign), .o_exp(add_exp), .o_sig(add_sig),
        .o_special(add_special), .o_special_sign(add_special_sign)
    );

    fp_mul #(.EXP_W(EXP_W), .MAN_W(MAN_W)) u_mul (
        .sign_a(sign_a), .exp_a(exp_a), .sig_a(sig_a), .cls_a(cls_a),
        .sign_b(sign_b), .exp_b(exp_b), .sig_b(sig_b), .cls_b(cls_b),
        .o_sign(mul_sign), .o_exp(mul_exp), .o_sig(mul_sig),
        .o_special(mul_special), .o_special_sign(mul_special_sign)
    );

    // Bit 1 of the code picks the multiplier
    fp_pack #(.EXP_W(EXP_W), .MAN_W(MAN_W)) u_pack (
        .add_sign(add_sign), .add_exp(add_exp), .add_sig(add_sig),
        .add_special(add_special), .add_special_sign(add_special_sign),
        .mul_sign(mul_sign), .mul_exp(mul_exp), .mul_sig(mul_sig),
        .mul_special(mul_special), .mul_special_sign(mul_special_sign),
        .sel_mul(op_q[1]), .res_next(res_next), .flags_next(flags_next)
    );

endmodule

// ==== tests/fpu_chk.sv ====
module fpu_chk
    import fpu_pkg::*;
#(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 start,
    input logic                 valid_out,
    input logic [EXP_W+MAN_W:0] result,
    input logic [FLAG_W-1:0]    flags
);

    localparam logic [EXP_W+MAN_W:0] QNAN = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MAN_W - 1){1'b0}}};

    int unsigned fail_count = 0;
    logic        busy;
    logic        accept;

    // Compute lasts one cycle, so busy simply follows an accepted start
    assign accept = start && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= accept;
        end
    end

    // ========================================================
    // Start/valid protocol
    // ========================================================

    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        valid_out |=> !valid_out)
        else begin
            fail_count++;
            $error("valid_out stayed high for two cycles");
        end

    a_start_to_valid: assert property (@(posedge clk) disable iff (rst)
        accept |-> ##2 valid_out)
        else begin
            fail_count++;
            $error("Accepted start not followed by valid_out two edges later");
        end

    a_valid_has_start: assert property (@(posedge clk) disable iff (rst)
        $rose(valid_out) |-> $past(accept, 2))
        else begin
            fail_count++;
            $error("valid_out rose without an accepted start");
        end

    // Invalid operation always returns the quiet NaN
    a_invalid_qnan: assert property (@(posedge clk) disable iff (rst)
        flags[FLAG_INVALID] |-> result == QNAN)
        else begin
            fail_count++;
            $error("Invalid flag set without the quiet NaN result");
        end

endmodule

bind fpu_top fpu_chk #(
    .EXP_W(EXP_W),
    .MAN_W(MAN_W)
) u_chk (
    .clk(clk),
    .rst(rst),
    .start(start),
    .valid_out(valid_out),
    .result(result),
    .flags(flags)
);

// ==== tests/fpu_tb.sv ====
module fpu_tb
    import fpu_pkg::*;
();

    localparam int N_RANDOM    = 300;
    localparam int N_DIR       = 40;
    localparam int CYCLE_LIMIT = 4 * (N_DIR + 3 * N_RANDOM + 1) + 100;
    localparam logic [31:0] QNAN = 32'h7fc00000;

    // Each entry is {code, a, b}
    localparam logic [65:0] DIRECTED [N_DIR] = '{
        {2'd0, 32'h3f800000, 32'h3f800000},
        {2'd0, 32'h3fc00000, 32'hbe800000},
        {2'd1, 32'h3f800000, 32'h3f800000},
        {2'd0, 32'hc0200000, 32'h40200000},
        {2'd0, 32'h3f800000, 32'h30800000},
        {2'd1, 32'h3f800000, 32'h30800000},
        {2'd1, 32'h3f800000, 32'h00800000},
        {2'd0, 32'h4b800000, 32'h3f800000},
        {2'd1, 32'h40400000, 32'h403fffff},
        {2'd0, 32'h7f7fffff, 32'h7f7fffff},
        {2'd1, 32'h00800001, 32'h00800000},
        {2'd1, 32'h3f800001, 32'hbf800000},
        {2'd2, 32'h3fc00000, 32'h3fc00000},
        {2'd2, 32'h3fffffff, 32'h3fffffff},
        {2'd2, 32'hc0400000, 32'h40800000},
        {2'd2, 32'h7f000000, 32'h40000000},
        {2'd2, 32'hff000000, 32'h40000000},
        {2'd2, 32'h00800000, 32'h3f000000},
        {2'd2, 32'h80800000, 32'h3f000000},
        {2'd3, 32'h40000000, 32'h40400000},
        {2'd0, 32'h7fc00000, 32'h3f800000},
        {2'd1, 32'h3f800000, 32'h7f800001},
        {2'd0, 32'h7f800000, 32'hff800000},
        {2'd1, 32'h7f800000, 32'h7f800000},
        {2'd0, 32'h7f800000, 32'h7f800000},
        {2'd0, 32'hff800000, 32'h40a00000},
        {2'd1, 32'h40a00000, 32'h7f800000},
        {2'd0, 32'h00000000, 32'h80000000},
        {2'd0, 32'h80000000, 32'h80000000},
        {2'd1, 32'h80000000, 32'h00000000},
        {2'd0, 32'h00000001, 32'h3f800000},
        {2'd1, 32'h3f800000, 32'h80400000},
        {2'd2, 32'h7fc00000, 32'h40000000},
        {2'd2, 32'h00000000, 32'h7f800000},
        {2'd2, 32'hff800000, 32'h80000000},
        {2'd2, 32'h7f800000, 32'hc0000000},
        {2'd2, 32'h80000000, 32'h40a00000},
        {2'd2, 32'h00400000, 32'h40400000},
        {2'd2, 32'h80000001, 32'h3f800000},
        {2'd2, 32'hff800000, 32'hff800000}
    };

    logic        clk;
    logic        rst;
    logic        start;
    op_e         op;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] result;
    logic [3:0]  flags;
    logic        valid_out;

    // Expected {flags, result} per outstanding operation
    logic [35:0] pending[$];
    int          seed;

    fpu_top DUT (
        .clk(clk),
        .rst(rst),
        .start(start),
        .op(op),
        .op_a(op_a),
        .op_b(op_b),
        .result(result),
        .flags(flags),
        .valid_out(valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================================
    // Reference model
    // ========================================================

    function automatic cls_t classify(input logic [31:0] w);
        if (w[30:23] == 8'hff) begin
            return (w[22:0] == 23'h0) ? CLS_INF : CLS_NAN;
        end
        return (w[30:23] == 8'h00) ? CLS_ZERO : CLS_NORMAL;
    endfunction

    // Bit p of the exact magnitude has biased exponent scale + p
    function automatic logic [35:0] pack_exact(input logic s, input int scale,
                                               input logic [127:0] mag);
        int           p;
        int           e;
        logic [3:0]   fl;
        logic [22:0]  frac;
        logic [127:0] rest_mask;
        p  = -1;
        fl = 4'h0;
        for (int i = 0; i < 128; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        if (p < 0) begin
            return {4'h0, 32'h0};
        end
        e = scale + p;
        fl[FLAG_INEXACT] = 1'b1;
        if (e >= 255) begin
            fl[FLAG_OVERFLOW] = 1'b1;
            return {fl, s, 8'hff, 23'h0};
        end
        if (e <= 0) begin
            fl[FLAG_UNDERFLOW] = 1'b1;
            return {fl, s, 31'h0};
        end
        frac      = 23'(mag >> (p - 23));
        rest_mask = (128'd1 << (p - 23)) - 128'd1;
        fl[FLAG_INEXACT] = |(mag & rest_mask);
        return {fl, s, 8'(e), frac};
    endfunction

    function automatic logic [35:0] fp_ref(input logic [1:0] code, input logic [31:0] a,
                                           input logic [31:0] b);
        logic         sa;
        logic         sb;
        logic         s;
        logic [7:0]   el;
        logic [7:0]   es;
        logic [23:0]  ml;
        logic [23:0]  ms;
        cls_t         ca;
        cls_t         cb;
        logic [127:0] big_l;
        logic [127:0] big_s;
        logic [127:0] mag;
        logic [63:0]  prod;
        logic [3:0]   fl;
        int           diff;
        sa = a[31];
        sb = b[31];
        ca = classify(a);
        cb = classify(b);
        fl = 4'h0;
        fl[FLAG_INVALID] = 1'b1;
        if (code[1]) begin
            s = sa ^ sb;
            if (ca == CLS_NAN || cb == CLS_NAN || (ca == CLS_ZERO && cb == CLS_INF) ||
                (ca == CLS_INF && cb == CLS_ZERO)) begin
                return {fl, QNAN};
            end
            if (ca == CLS_INF || cb == CLS_INF) begin
                return {4'h0, s, 8'hff, 23'h0};
            end
            if (ca == CLS_ZERO || cb == CLS_ZERO) begin
                return {4'h0, s, 31'h0};
            end
            prod = 64'({1'b1, a[22:0]}) * 64'({1'b1, b[22:0]});
            return pack_exact(s, int'(a[30:23]) + int'(b[30:23]) - 127 - 46, {64'h0, prod});
        end
        // Subtract is add with b negated
        sb = sb ^ code[0];
        if (ca == CLS_NAN || cb == CLS_NAN || (ca == CLS_INF && cb == CLS_INF && sa != sb)) begin
            return {fl, QNAN};
        end
        if (ca == CLS_INF) begin
            return {4'h0, sa, 8'hff, 23'h0};
        end
        if (cb == CLS_INF) begin
            return {4'h0, sb, 8'hff, 23'h0};
        end
        if (ca == CLS_ZERO && cb == CLS_ZERO) begin
            return {4'h0, sa & sb, 31'h0};
        end
        if (ca == CLS_ZERO) begin
            return {4'h0, sb, b[30:0]};
        end
        if (cb == CLS_ZERO) begin
            return {4'h0, sa, a[30:0]};
        end
        // Larger magnitude sets the sign and a wins a tie
        if (b[30:0] > a[30:0]) begin
            s  = sb;
            el = b[30:23];
            ml = {1'b1, b[22:0]};
            es = a[30:23];
            ms = {1'b1, a[22:0]};
        end else begin
            s  = sa;
            el = a[30:23];
            ml = {1'b1, a[22:0]};
            es = b[30:23];
            ms = {1'b1, b[22:0]};
        end
        diff  = int'(el) - int'(es);
        big_l = 128'(ml) << 60;
        if (diff > 60) begin
            // Only the presence of a far smaller operand matters
            big_s = 128'd1;
        end else begin
            big_s = (128'(ms) << 60) >> diff;
        end
        mag = (sa != sb) ? big_l - big_s : big_l + big_s;
        return pack_exact(s, int'(el) - 83, mag);
    endfunction

    // ========================================================
    // Checking
    // ========================================================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error: %s is %h, expected %h", name, got, want);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    initial begin : compare
        logic [35:0] want;
        forever begin
            @(negedge clk);
            if (DUT.u_chk.fail_count != 0) begin
                $display("A protocol assertion in the bound checker failed");
                $display("*** FAILED ***");
                $fatal(1, "Protocol assertion failure");
            end
            if (valid_out) begin
                if (pending.size() == 0) begin
                    $display("valid_out pulsed with no operation outstanding");
                    $display("*** FAILED ***");
                    $fatal(1, "Unexpected completion");
                end
                want = pending.pop_front();
                check_value("result", result, want[31:0]);
                check_value("flags", {28'h0, flags}, {28'h0, want[35:32]});
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("*** FAILED ***");
                $fatal(1, "Timeout");
            end
        end
    end

    // ========================================================
    // Stimulus
    // ========================================================

    // Two cycles per operation with start sampled on the second edge
    task automatic issue(input logic [1:0] code, input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        #1;
        start = 1'b1;
        op    = op_e'(code);
        op_a  = a;
        op_b  = b;
        pending.push_back(fp_ref(code, a, b));
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        logic [35:0] t_exp;
        rst   = 1'b1;
        start = 1'b0;
        op    = OP_ADD;
        op_a  = 32'h0;
        op_b  = 32'h0;
        seed  = 32'hb1cf5b37;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("result", result, 32'h0);
        check_value("flags", {28'h0, flags}, 32'h0);
        check_value("valid_out", {31'h0, valid_out}, 32'h0);

        // Start held high through the compute cycle counts once
        t_exp = fp_ref(2'd2, 32'h40000000, 32'h40400000);
        @(posedge clk);
        #1;
        start = 1'b1;
        op    = OP_MUL;
        op_a  = 32'h40000000;
        op_b  = 32'h40400000;
        pending.push_back(t_exp);
        @(negedge clk);
        check_value("valid_out", {31'h0, valid_out}, 32'h0);
        // Start sampled here
        @(posedge clk);
        @(negedge clk);
        check_value("valid_out", {31'h0, valid_out}, 32'h0);
        // Compute edge with start still high
        @(posedge clk);
        #1;
        start = 1'b0;
        op    = OP_ADD;
        op_a  = 32'h3f800000;
        op_b  = 32'h3f800000;
        @(negedge clk);
        check_value("valid_out", {31'h0, valid_out}, 32'h1);
        repeat (4) begin
            @(negedge clk);
            check_value("valid_out", {31'h0, valid_out}, 32'h0);
            check_value("result", result, t_exp[31:0]);
        end

        for (int i = 0; i < N_DIR; i++) begin
            issue(DIRECTED[i][65:64], DIRECTED[i][63:32], DIRECTED[i][31:0]);
        end

        for (int code = 0; code < 3; code++) begin
            for (int i = 0; i < N_RANDOM; i++) begin
                a = $random(seed);
                b = $random(seed);
                // Half the pairs kept in a useful exponent range
                if (i % 2 == 0) begin
                    if (code == 2) begin
                        a[30:28] = 3'b011;
                        b[30:28] = 3'b100;
                    end else begin
                        b[30:23] = a[30:23] - 8'(i % 4);
                    end
                end
                issue(2'(code), a, b);
            end
        end

        while (pending.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (DUT.u_chk.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src.f ====
verilog/fpu_pkg.sv
verilog/fp_unpack.sv
verilog/fp_addsub.sv
verilog/fp_mul.sv
verilog/fp_pack.sv
verilog/fpu_ctrl.sv
verilog/fpu_top.sv
tests/fpu_chk.sv
tests/fpu_tb.sv

// ==== Makefile ====
TOP := fpu_tb

all: run

obj_dir/V$(TOP): src.f $(wildcard verilog/*.sv tests/*.sv)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only -Wall --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
